/* muldiv_pkg.sv */
/*
  shared types and function codes for the integer multiply/divide unit
  imported by the dispatcher, both iterative units and the top level
*/
package muldiv_pkg;

  // ------------------------------------------------
  // data widths
  // ------------------------------------------------

  // one machine word
  typedef logic [31:0] operand_t;

  // full product, or remainder in the upper word and quotient in the lower
  typedef logic [63:0] result_t;

  // ------------------------------------------------
  // function codes
  // ------------------------------------------------

  typedef logic [1:0] fn_t;

  localparam fn_t fn_mul  = 2'd0;
  localparam fn_t fn_div  = 2'd1;
  localparam fn_t fn_divu = 2'd2;

  // ------------------------------------------------
  // messages
  // ------------------------------------------------

  typedef struct packed {
    fn_t      fn;
    operand_t a;
    operand_t b;
  } muldiv_req_t;

  typedef struct packed {
    result_t result;
  } muldiv_resp_t;

  // which unit owns an outstanding request
  typedef logic unit_tag_t;

  localparam unit_tag_t tag_mul = 1'b0;
  localparam unit_tag_t tag_div = 1'b1;

  // control states shared by both iterative units
  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } ctrl_state_t;

endpackage

/* int_mul_iterative.sv */
/*
  iterative signed multiplier, one product bit per cycle over 32 cycles
  val/rdy on both the request and the response side
*/
module int_mul_iterative (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  output logic                     req_rdy,
  input  muldiv_pkg::muldiv_req_t  req_msg,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output muldiv_pkg::muldiv_resp_t resp_msg
);

  import muldiv_pkg::*;

  ctrl_state_t state_q;
  logic [5:0]  count_q;

  // datapath registers
  result_t  mcand_q;
  operand_t mplier_q;
  result_t  acc_q;
  logic     neg_q;

  logic     req_go;
  logic     resp_go;
  logic     last_iter;
  operand_t a_mag;
  operand_t b_mag;
  result_t  acc_next;

  // ------------------------------------------------
  // handshake and control
  // ------------------------------------------------

  assign req_rdy   = (state_q == st_idle);
  assign resp_val  = (state_q == st_done);
  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_iter = (count_q == 6'd31);

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      count_q <= 6'd0;
    end else begin
      case (state_q)
        st_idle: begin
          if (req_go) begin
            state_q <= st_calc;
            count_q <= 6'd0;
          end
        end
        st_calc: begin
          // 32 iterations with count 0 through 31
          if (last_iter) begin
            state_q <= st_done;
          end else begin
            count_q <= count_q + 6'd1;
          end
        end
        st_done: begin
          // free again on the transfer edge
          if (resp_go) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // ------------------------------------------------
  // datapath
  // ------------------------------------------------

  // work on magnitudes, fix the sign at the end
  assign a_mag = req_msg.a[31] ? -req_msg.a : req_msg.a;
  assign b_mag = req_msg.b[31] ? -req_msg.b : req_msg.b;

  // add the shifted multiplicand when the low multiplier bit is set
  assign acc_next = mplier_q[0] ? acc_q + mcand_q : acc_q;

  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand_q  <= {32'b0, a_mag};
      mplier_q <= b_mag;
      acc_q    <= '0;
      neg_q    <= req_msg.a[31] ^ req_msg.b[31];
    end else if (state_q == st_calc) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
      // negate once on the way into done
      if (last_iter && neg_q) begin
        acc_q <= -acc_next;
      end else begin
        acc_q <= acc_next;
      end
    end
  end

  assign resp_msg.result = acc_q;

  // response held steady while the consumer stalls
  a_resp_stable: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_msg)));

endmodule

/* int_div_iterative.sv */
/*
  iterative restoring divider for signed and unsigned 32-bit operands
  result packs the remainder in the upper word and the quotient in the lower
*/
module int_div_iterative (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  output logic                     req_rdy,
  input  muldiv_pkg::muldiv_req_t  req_msg,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output muldiv_pkg::muldiv_resp_t resp_msg
);

  import muldiv_pkg::*;

  ctrl_state_t state_q;
  logic [5:0]  count_q;

  // datapath registers
  logic [64:0] rq_q;
  logic [64:0] dv_q;
  logic        a_neg_q;
  logic        b_neg_q;
  logic        zero_q;
  operand_t    a_orig_q;

  logic        req_go;
  logic        resp_go;
  logic        is_signed;
  logic        a_neg;
  logic        b_neg;
  operand_t    a_mag;
  operand_t    b_mag;
  logic [64:0] rq_shift;
  logic [64:0] diff;
  logic [64:0] rq_next;
  operand_t    q_mag;
  operand_t    r_mag;
  operand_t    quot;
  operand_t    rem;

  // ------------------------------------------------
  // handshake and control
  // ------------------------------------------------

  assign req_rdy  = (state_q == st_idle);
  assign resp_val = (state_q == st_done);
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      count_q <= 6'd0;
    end else begin
      case (state_q)
        st_idle: begin
          if (req_go) begin
            state_q <= st_calc;
            count_q <= 6'd0;
          end
        end
        st_calc: begin
          if (count_q == 6'd31) begin
            state_q <= st_done;
          end else begin
            count_q <= count_q + 6'd1;
          end
        end
        st_done: begin
          if (resp_go) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // ------------------------------------------------
  // operand preparation
  // ------------------------------------------------

  // only fn_div treats the operands as signed
  assign is_signed = (req_msg.fn == fn_div);
  assign a_neg     = is_signed && req_msg.a[31];
  assign b_neg     = is_signed && req_msg.b[31];
  assign a_mag     = a_neg ? -req_msg.a : req_msg.a;
  assign b_mag     = b_neg ? -req_msg.b : req_msg.b;

  // ------------------------------------------------
  // restoring step
  // ------------------------------------------------

  assign rq_shift = {rq_q[63:0], 1'b0};
  assign diff     = rq_shift - dv_q;

  // keep the difference only when it did not go negative
  assign rq_next = diff[64] ? rq_shift : {diff[64:1], 1'b1};

  always_ff @(posedge clk) begin
    if (req_go) begin
      rq_q     <= {33'b0, a_mag};
      dv_q     <= {1'b0, b_mag, 32'b0};
      a_neg_q  <= a_neg;
      b_neg_q  <= b_neg;
      zero_q   <= (req_msg.b == '0);
      a_orig_q <= req_msg.a;
    end else if (state_q == st_calc) begin
      rq_q <= rq_next;
    end
  end

  // ------------------------------------------------
  // sign fix and special cases
  // ------------------------------------------------

  assign q_mag = rq_q[31:0];
  assign r_mag = rq_q[63:32];

  // most negative by minus one falls out as the dividend with zero remainder
  always_comb begin
    if (zero_q) begin
      quot = '1;
      rem  = a_orig_q;
    end else begin
      quot = (a_neg_q ^ b_neg_q) ? -q_mag : q_mag;
      rem  = a_neg_q ? -r_mag : r_mag;
    end
  end

  assign resp_msg.result = {rem, quot};

  // once accepted, busy for the whole calc phase
  a_busy_after_accept: assert property (@(posedge clk) disable iff (reset)
    req_go |=> !req_rdy [*32]);

  a_resp_stable: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_msg)));

endmodule

/* muldiv_dispatch.sv */
/*
  steers requests to the multiplier or divider and returns responses in order
  a small tag queue remembers which unit owns each outstanding request
*/
module muldiv_dispatch #(
  parameter int ORDER_DEPTH = 2
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  output logic                     req_rdy,
  input  muldiv_pkg::muldiv_req_t  req_msg,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output muldiv_pkg::muldiv_resp_t resp_msg,
  output logic                     mul_req_val,
  input  logic                     mul_req_rdy,
  output logic                     div_req_val,
  input  logic                     div_req_rdy,
  output muldiv_pkg::muldiv_req_t  unit_req_msg,
  input  logic                     mul_resp_val,
  output logic                     mul_resp_rdy,
  input  muldiv_pkg::muldiv_resp_t mul_resp_msg,
  input  logic                     div_resp_val,
  output logic                     div_resp_rdy,
  input  muldiv_pkg::muldiv_resp_t div_resp_msg
);

  import muldiv_pkg::*;

  localparam int PTR_W = $clog2(ORDER_DEPTH);

  unit_tag_t        order_q [ORDER_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W:0]   count_q;

  logic      q_full;
  logic      q_empty;
  logic      push;
  logic      pop;
  unit_tag_t target;
  unit_tag_t head;
  logic      target_rdy;

  assign q_full  = (count_q == (PTR_W + 1)'(ORDER_DEPTH));
  assign q_empty = (count_q == '0);

  // ------------------------------------------------
  // accept and route
  // ------------------------------------------------

  assign target     = (req_msg.fn == fn_mul) ? tag_mul : tag_div;
  assign target_rdy = (target == tag_mul) ? mul_req_rdy : div_req_rdy;

  assign req_rdy      = target_rdy && !q_full;
  assign mul_req_val  = req_val && !q_full && (target == tag_mul);
  assign div_req_val  = req_val && !q_full && (target == tag_div);
  assign unit_req_msg = req_msg;
  assign push         = req_val && req_rdy;

  // ------------------------------------------------
  // in-order response
  // ------------------------------------------------

  // only the unit at the head may talk to the outside
  assign head         = order_q[rd_ptr_q];
  assign resp_val     = !q_empty && ((head == tag_mul) ? mul_resp_val : div_resp_val);
  assign resp_msg     = (head == tag_mul) ? mul_resp_msg : div_resp_msg;
  assign mul_resp_rdy = resp_rdy && !q_empty && (head == tag_mul);
  assign div_resp_rdy = resp_rdy && !q_empty && (head == tag_div);
  assign pop          = resp_val && resp_rdy;

  // ------------------------------------------------
  // order queue
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // tag storage
  always_ff @(posedge clk) begin
    if (push) begin
      order_q[wr_ptr_q] <= target;
    end
  end

  // an empty queue never wraps below zero on the next edge
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    q_empty |=> (count_q <= (PTR_W + 1)'(1)));

  // a full queue never grows past its depth on the next edge
  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    q_full |=> (count_q <= (PTR_W + 1)'(ORDER_DEPTH)));

endmodule

/* muldiv_unit.sv */
/*
  top level of the multiply/divide unit
  dispatcher in front of an iterative multiplier and an iterative divider
*/
module muldiv_unit #(
  parameter int ORDER_DEPTH = 2
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  output logic                     req_rdy,
  input  muldiv_pkg::muldiv_req_t  req_msg,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output muldiv_pkg::muldiv_resp_t resp_msg
);

  import muldiv_pkg::*;

  // one request message shared by both units
  muldiv_req_t  unit_req_msg;
  logic         mul_req_val;
  logic         mul_req_rdy;
  logic         div_req_val;
  logic         div_req_rdy;

  // response side
  logic         mul_resp_val;
  logic         mul_resp_rdy;
  muldiv_resp_t mul_resp_msg;
  logic         div_resp_val;
  logic         div_resp_rdy;
  muldiv_resp_t div_resp_msg;

  muldiv_dispatch #(
    .ORDER_DEPTH (ORDER_DEPTH)
  ) i_dispatch (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .req_msg      (req_msg),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .resp_msg     (resp_msg),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .unit_req_msg (unit_req_msg),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .mul_resp_msg (mul_resp_msg),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy),
    .div_resp_msg (div_resp_msg)
  );

  int_mul_iterative i_mul (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .req_msg  (unit_req_msg),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .resp_msg (mul_resp_msg)
  );

  int_div_iterative i_div (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .req_msg  (unit_req_msg),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .resp_msg (div_resp_msg)
  );

endmodule

/* tb_muldiv_unit.sv */
/*
  testbench for the multiply/divide unit with a table of worked vectors,
  latency and ordering checks, and a random stream checked against a reference model
*/
module tb_muldiv_unit;

  timeunit 1ns;
  timeprecision 1ps;

  import muldiv_pkg::*;

  // --------------------------------------------------
  // limits and timing
  // --------------------------------------------------

  localparam int rdy_timeout   = 400;
  localparam int drain_timeout = 400;
  // 32 cycles in calc before resp_val rises
  localparam int calc_edges    = 32;

  typedef struct packed {
    fn_t      fn;
    operand_t a;
    operand_t b;
    result_t  want;
  } vec_t;

  logic         clk;
  logic         reset;
  logic         req_val;
  logic         req_rdy;
  muldiv_req_t  req_msg;
  logic         resp_val;
  logic         resp_rdy;
  muldiv_resp_t resp_msg;

  logic [31:0]  lcg_state;
  result_t      exp_q[$];
  vec_t         vec_tab [16];
  logic         rdy_pat [64];
  logic         stream_done;
  int           errors;
  int           tests_run;
  int           tests_failed;

  muldiv_unit #(
    .ORDER_DEPTH (2)
  ) i_muldiv_unit (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  always #4 clk = ~clk;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  function automatic operand_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // reference arithmetic including the zero divisor and overflow rules
  function automatic result_t ref_result(input fn_t op_fn, input operand_t op_a,
                                         input operand_t op_b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    int                 qs;
    int                 rs;
    result_t            res;
    if (op_fn == fn_mul) begin
      sa  = {{32{op_a[31]}}, op_a};
      sb  = {{32{op_b[31]}}, op_b};
      res = sa * sb;
    end else if (op_b == '0) begin
      res = {op_a, 32'hffff_ffff};
    end else if (op_fn == fn_divu) begin
      res = {op_a % op_b, op_a / op_b};
    end else if (op_a == 32'h8000_0000 && op_b == 32'hffff_ffff) begin
      res = {32'h0, op_a};
    end else begin
      // int division truncates and the remainder follows the dividend
      qs  = int'(op_a) / int'(op_b);
      rs  = int'(op_a) % int'(op_b);
      res = {operand_t'(rs), operand_t'(qs)};
    end
    return res;
  endfunction

  // hold the request until req_rdy and queue its expected result at the transfer
  task automatic send_req(input fn_t op_fn, input operand_t op_a, input operand_t op_b,
                          input result_t want);
    int   waited;
    logic took;
    waited  = 0;
    took    = 1'b0;
    req_val = 1'b1;
    req_msg = '{fn: op_fn, a: op_a, b: op_b};
    while (!took && waited < rdy_timeout) begin
      @(negedge clk);
      if (req_rdy) begin
        took = 1'b1;
      end else begin
        waited++;
      end
    end
    @(posedge clk);
    if (took) begin
      exp_q.push_back(want);
    end else begin
      $display("timeout: request with fn %0d not accepted in %0d cycles", op_fn, rdy_timeout);
      errors++;
    end
    #1;
    req_val = 1'b0;
  endtask

  // returns 1 ns after the edge that takes the last response
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_timeout) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d responses still missing after %0d cycles",
               exp_q.size(), drain_timeout);
      errors++;
      exp_q.delete();
    end
    #1;
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end
  endtask

  // --------------------------------------------------
  // response monitor, in request order
  // --------------------------------------------------

  // sampled at the falling edge where outputs are stable before the transfer edge
  always @(negedge clk) begin
    result_t want;
    if (!reset && resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        $display("response arrived with no request outstanding");
        errors++;
      end else begin
        want = exp_q.pop_front();
        if (resp_msg.result !== want) begin
          $display("** Error: resp_msg expected %h actual %h", want, resp_msg.result);
          errors++;
        end
      end
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  initial begin
    int       i;
    int       k;
    int       n;
    int       blocked_bad;
    int       err_before;
    logic     seen;
    operand_t r;
    fn_t      op_fn;
    operand_t op_a;
    operand_t op_b;

    clk          = 1'b0;
    reset        = 1'b1;
    req_val      = 1'b0;
    req_msg      = '0;
    resp_rdy     = 1'b1;
    lcg_state    = 32'h74fc_3617;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;

    // expected results worked by hand with the remainder in the high word
    vec_tab[0]  = '{fn_mul,  32'd7,         32'd6,         64'h0000_0000_0000_002a};
    vec_tab[1]  = '{fn_mul,  32'hffff_fffd, 32'd5,         64'hffff_ffff_ffff_fff1};
    vec_tab[2]  = '{fn_mul,  32'hffff_fffc, 32'hffff_fff7, 64'h0000_0000_0000_0024};
    vec_tab[3]  = '{fn_mul,  32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000};
    vec_tab[4]  = '{fn_div,  32'd100,       32'd7,         64'h0000_0002_0000_000e};
    vec_tab[5]  = '{fn_div,  32'hffff_ff9c, 32'd7,         64'hffff_fffe_ffff_fff2};
    vec_tab[6]  = '{fn_div,  32'd100,       32'hffff_fff9, 64'h0000_0002_ffff_fff2};
    vec_tab[7]  = '{fn_divu, 32'hffff_ff9c, 32'd7,         64'h0000_0002_2492_4916};
    vec_tab[8]  = '{fn_div,  32'h8000_0000, 32'd3,         64'hffff_fffe_d555_5556};
    vec_tab[9]  = '{fn_divu, 32'h8000_0000, 32'd3,         64'h0000_0002_2aaa_aaaa};
    vec_tab[10] = '{fn_div,  32'hffff_ffff, 32'h10,        64'hffff_ffff_0000_0000};
    vec_tab[11] = '{fn_divu, 32'hffff_ffff, 32'h10,        64'h0000_000f_0fff_ffff};
    vec_tab[12] = '{fn_div,  32'h0000_1234, 32'd0,         64'h0000_1234_ffff_ffff};
    vec_tab[13] = '{fn_divu, 32'hdead_beef, 32'd0,         64'hdead_beef_ffff_ffff};
    vec_tab[14] = '{fn_div,  32'h8000_0000, 32'hffff_ffff, 64'h0000_0000_8000_0000};
    vec_tab[15] = '{fn_divu, 32'h8000_0000, 32'hffff_ffff, 64'h8000_0000_0000_0000};

    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // idle after reset
    err_before = errors;
    @(negedge clk);
    if (req_rdy !== 1'b1 || resp_val !== 1'b0) begin
      $display("** Error: req_rdy/resp_val expected 1/0 actual %h/%h", req_rdy, resp_val);
      errors++;
    end
    @(posedge clk);
    #1;
    report_test("after reset", err_before);

    // one vector at a time
    for (i = 0; i < 16; i++) begin
      err_before = errors;
      send_req(vec_tab[i].fn, vec_tab[i].a, vec_tab[i].b, vec_tab[i].want);
      wait_drain();
      report_test($sformatf("table %0d fn %0d", i, vec_tab[i].fn), err_before);
    end

    // lone request into an idle unit
    err_before = errors;
    send_req(fn_mul, 32'h0001_0001, 32'h0000_ffff, 64'h0000_0000_ffff_ffff);
    n    = 0;
    seen = 1'b0;
    while (!seen && n < drain_timeout) begin
      @(negedge clk);
      if (resp_val) begin
        seen = 1'b1;
      end else begin
        n++;
      end
    end
    if (!seen) begin
      $display("timeout: no response for the lone multiply");
      errors++;
    end else if (n != calc_edges) begin
      $display("** Error: resp_val latency expected %h actual %h", calc_edges, n);
      errors++;
    end
    wait_drain();
    report_test("lone request latency", err_before);

    // divide then multiply under back-pressure while a third request stalls
    err_before = errors;
    resp_rdy   = 1'b0;
    send_req(fn_div, 32'd1000, 32'd9, 64'h0000_0001_0000_006f);
    send_req(fn_mul, 32'hffff_fffe, 32'd3, 64'hffff_ffff_ffff_fffa);
    req_val     = 1'b1;
    req_msg     = '{fn: fn_div, a: 32'd50, b: 32'd5};
    blocked_bad = 0;
    for (i = 0; i < 50; i++) begin
      @(negedge clk);
      if (req_rdy) begin
        blocked_bad++;
      end
    end
    if (blocked_bad != 0) begin
      $display("** Error: req_rdy expected 0 actual 1 with two requests outstanding");
      errors++;
    end
    // the finished divide waits at the head
    if (resp_val !== 1'b1) begin
      $display("** Error: resp_val expected 1 actual %h under back-pressure", resp_val);
      errors++;
    end
    @(posedge clk);
    #1;
    resp_rdy = 1'b1;
    send_req(fn_div, 32'd50, 32'd5, 64'h0000_0000_0000_000a);
    wait_drain();
    report_test("ordering under back-pressure", err_before);

    // random stream with a stalling consumer
    err_before = errors;
    for (i = 0; i < 64; i++) begin
      r          = lcg_next();
      rdy_pat[i] = r[20];
    end
    stream_done = 1'b0;
    fork
      begin
        for (i = 0; i < 40; i++) begin
          r     = lcg_next();
          op_fn = fn_t'(r % 32'd3);
          op_a  = lcg_next();
          op_b  = lcg_next();
          // pull some operands onto the corner cases
          case (r[31:29])
            3'd0:    op_b = '0;
            3'd1:    op_b = op_b & 32'h0000_00ff;
            3'd2:    op_b = 32'hffff_ffff;
            3'd3:    op_a = 32'h8000_0000;
            default: ;
          endcase
          send_req(op_fn, op_a, op_b, ref_result(op_fn, op_a, op_b));
        end
        stream_done = 1'b1;
      end
      begin
        k = 0;
        while (!stream_done) begin
          @(posedge clk);
          #1;
          resp_rdy = rdy_pat[k % 64];
          k++;
        end
        resp_rdy = 1'b1;
      end
    join
    wait_drain();
    report_test("random stream", err_before);

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
muldiv_pkg.sv
int_mul_iterative.sv
int_div_iterative.sv
muldiv_dispatch.sv
muldiv_unit.sv
tb_muldiv_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the multiply/divide testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_muldiv_unit -f files.f -o sim_muldiv > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_muldiv > sim.log 2>&1 || echo "simulator exited with an error status"

grep -q "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "run ended early, see sim.log"; exit 1; }
echo "simulation passed"
